// File: wca_pkg.sv
package wca_pkg;

    // ====================
    // Controller and mode encodings
    // ====================
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,   // Waiting for configuration
        ST_CFG  = 2'd1,   // One-cycle configuration step
        ST_WORK = 2'd2    // Serving requests
    } wca_state_e;

    typedef enum logic {
        MODE_BYPASS = 1'b0,   // Every request reads the RAM
        MODE_CACHE  = 1'b1
    } wca_mode_e;

    // ====================
    // Default sizes
    // ====================
    localparam int NUM_PORTS_DEF = 4;    // PE rows
    localparam int ADDR_W_DEF    = 13;   // Weight RAM address
    localparam int DATA_W_DEF    = 8;
    localparam int TAG_W_DEF     = 8;    // Stat index
    localparam int SLOT_NUM_DEF  = 32;   // Must stay a power of two

endpackage

// File: wca_cfg_ctrl.sv
`timescale 1ns/1ps

module wca_cfg_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cfg_info_vld,
    input  logic                cfg_wbuf_ena,
    output logic                cfg_info_rdy,
    output logic                work,
    output wca_pkg::wca_mode_e  mode
);

    wca_pkg::wca_state_e state;
    wca_pkg::wca_state_e state_nxt;

    // ====================
    // State machine
    // ====================
    always_comb begin
        state_nxt = state;
        case (state)
            wca_pkg::ST_IDLE: begin
                if (cfg_info_vld) begin
                    state_nxt = wca_pkg::ST_CFG;
                end
            end
            wca_pkg::ST_CFG: state_nxt = wca_pkg::ST_WORK;
            wca_pkg::ST_WORK: begin
                if (cfg_info_vld) begin
                    state_nxt = wca_pkg::ST_IDLE;   // Abort back to idle
                end
            end
            default: state_nxt = wca_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= wca_pkg::ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Mode sampled on the step into work
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode <= wca_pkg::MODE_BYPASS;
        end else if (state == wca_pkg::ST_IDLE) begin
            mode <= wca_pkg::MODE_BYPASS;
        end else if (state == wca_pkg::ST_CFG) begin
            mode <= cfg_wbuf_ena ? wca_pkg::MODE_CACHE : wca_pkg::MODE_BYPASS;
        end
    end

    assign cfg_info_rdy = (state == wca_pkg::ST_IDLE);
    assign work         = (state == wca_pkg::ST_WORK);

endmodule

// File: wca_tag_store.sv
`timescale 1ns/1ps

module wca_tag_store #(
    parameter int NUM_PORTS = wca_pkg::NUM_PORTS_DEF,
    parameter int DATA_W    = wca_pkg::DATA_W_DEF,
    parameter int TAG_W     = wca_pkg::TAG_W_DEF,
    parameter int SLOT_NUM  = wca_pkg::SLOT_NUM_DEF
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                work,
    input  wca_pkg::wca_mode_e                  mode,
    input  logic                                idx_vld,
    input  logic [TAG_W-1:0]                    idx,
    output logic                                idx_rdy,
    input  logic [NUM_PORTS-1:0][TAG_W-1:0]     req_tag,
    output logic [NUM_PORTS-1:0]                hit,
    output logic [NUM_PORTS-1:0][DATA_W-1:0]    hit_data,
    input  logic                                fill,
    input  logic [$clog2(NUM_PORTS)-1:0]        fill_port,
    input  logic [DATA_W-1:0]                   fill_data
);

    localparam int SLOT_W = $clog2(SLOT_NUM);

    logic [SLOT_NUM-1:0][TAG_W-1:0]     idx_arr;
    logic [SLOT_NUM-1:0][DATA_W-1:0]    data_arr;
    logic [SLOT_NUM-1:0]                slot_used;   // Index loaded since work began
    logic [SLOT_NUM-1:0]                data_vld;
    logic [SLOT_W-1:0]                  load_ptr;

    logic [NUM_PORTS-1:0][SLOT_W-1:0]   first_slot;
    logic [NUM_PORTS-1:0]               match_any;

    logic                               load_en;
    logic [SLOT_W-1:0]                  fill_slot;
    logic                               fill_en;

    // ====================
    // Per-port lookup
    // ====================
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_lookup
        logic [SLOT_NUM-1:0]    match;
        logic [SLOT_W-1:0]      first_s;

        always_comb begin
            for (int s = 0; s < SLOT_NUM; s++) begin
                match[s] = slot_used[s] && (idx_arr[s] == req_tag[p]);
            end
        end

        // Lowest slot wins when an index sits in two slots
        always_comb begin
            first_s = '0;
            for (int s = SLOT_NUM - 1; s >= 0; s--) begin
                if (match[s]) begin
                    first_s = SLOT_W'(s);
                end
            end
        end

        assign first_slot[p] = first_s;
        assign match_any[p]  = |match;
        assign hit[p]        = (mode == wca_pkg::MODE_CACHE) && match_any[p]
                               && data_vld[first_s];
        assign hit_data[p]   = data_arr[first_s];
    end

    // ====================
    // Index load and fill
    // ====================
    assign idx_rdy   = work;
    assign load_en   = idx_vld && work;
    assign fill_slot = first_slot[fill_port];

    // A load into the same slot wins over the fill
    assign fill_en = fill && (mode == wca_pkg::MODE_CACHE) && match_any[fill_port]
                     && !(load_en && (load_ptr == fill_slot));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx_arr   <= '0;
            slot_used <= '0;
            data_vld  <= '0;
            load_ptr  <= '0;
        end else if (!work) begin
            idx_arr   <= '0;
            slot_used <= '0;
            data_vld  <= '0;
            load_ptr  <= '0;
        end else begin
            if (fill_en) begin
                data_vld[fill_slot] <= 1'b1;
            end
            if (load_en) begin
                idx_arr[load_ptr]   <= idx;
                slot_used[load_ptr] <= 1'b1;
                data_vld[load_ptr]  <= 1'b0;      // Old weight no longer belongs here
                load_ptr            <= load_ptr + 1'b1;   // Wraps at SLOT_NUM
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            data_arr[fill_slot] <= fill_data;
        end
    end

endmodule

// File: wca_req_arbiter.sv
`timescale 1ns/1ps

module wca_req_arbiter #(
    parameter int NUM_PORTS = wca_pkg::NUM_PORTS_DEF,
    parameter int ADDR_W    = wca_pkg::ADDR_W_DEF,
    parameter int DATA_W    = wca_pkg::DATA_W_DEF
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                work,
    input  logic [NUM_PORTS-1:0]                miss_vld,
    input  logic [NUM_PORTS-1:0][ADDR_W-1:0]    req_addr,
    output logic                                wram_add_vld,
    input  logic                                wram_add_rdy,
    output logic [ADDR_W-1:0]                   wram_add_add,
    input  logic                                wram_dat_vld,
    output logic                                wram_dat_rdy,
    input  logic [DATA_W-1:0]                   wram_dat_dat,
    output logic                                fill,
    output logic [$clog2(NUM_PORTS)-1:0]        fill_port,
    output logic [DATA_W-1:0]                   fill_data
);

    localparam int PORT_W = $clog2(NUM_PORTS);

    typedef enum logic [1:0] {
        ARB_IDLE = 2'd0,
        ARB_ADDR = 2'd1,   // Address held until accepted
        ARB_DATA = 2'd2    // Read outstanding
    } arb_state_e;

    arb_state_e         state;
    logic [PORT_W-1:0]  rr_ptr;
    logic [PORT_W-1:0]  grant_port;
    logic [ADDR_W-1:0]  addr_r;
    logic [PORT_W-1:0]  pick_port;
    logic               pick_vld;

    // ====================
    // Round-robin pick
    // ====================
    always_comb begin
        int cand;
        pick_vld  = 1'b0;
        pick_port = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            cand = int'(rr_ptr) + i;
            if (cand >= NUM_PORTS) begin
                cand = cand - NUM_PORTS;
            end
            if (!pick_vld && miss_vld[cand]) begin
                pick_vld  = 1'b1;
                pick_port = PORT_W'(cand);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ARB_IDLE;
            rr_ptr     <= '0;
            grant_port <= '0;
            addr_r     <= '0;
        end else if (!work) begin
            state      <= ARB_IDLE;
            rr_ptr     <= '0;
            grant_port <= '0;
            addr_r     <= '0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (pick_vld) begin
                        state      <= ARB_ADDR;
                        grant_port <= pick_port;
                        addr_r     <= req_addr[pick_port];
                        rr_ptr     <= (int'(pick_port) == NUM_PORTS - 1) ? '0 : pick_port + 1'b1;
                    end
                end
                ARB_ADDR: if (wram_add_rdy) state <= ARB_DATA;
                ARB_DATA: if (wram_dat_vld) state <= ARB_IDLE;
                default: state <= ARB_IDLE;
            endcase
        end
    end

    assign wram_add_vld = (state == ARB_ADDR);
    assign wram_add_add = addr_r;
    assign wram_dat_rdy = (state == ARB_DATA);

    assign fill      = work && (state == ARB_DATA) && wram_dat_vld;   // One cycle per read
    assign fill_port = grant_port;
    assign fill_data = wram_dat_dat;

endmodule

// File: wca_port_stage.sv
`timescale 1ns/1ps

module wca_port_stage #(
    parameter int DATA_W = wca_pkg::DATA_W_DEF
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                work,
    input  logic                req_vld,
    output logic                req_rdy,
    input  logic                hit,
    input  logic [DATA_W-1:0]   hit_data,
    output logic                miss_vld,
    input  logic                fill,
    input  logic [DATA_W-1:0]   fill_data,
    output logic                rsp_vld,
    input  logic                rsp_rdy,
    output logic [DATA_W-1:0]   rsp_dat
);

    logic   rsp_full;
    logic   miss_pend;    // Request committed to the RAM path
    logic   slot_free;
    logic   take_hit;
    logic   take_req;

    // ====================
    // Acceptance
    // ====================
    assign slot_free = !rsp_full || rsp_rdy;                 // Empty or draining
    assign take_hit  = hit && !miss_pend && slot_free;
    assign req_rdy   = work && (take_hit || fill);
    assign take_req  = req_vld && req_rdy;

    // Held until the fill strobe, even if the tag turns into a hit meanwhile
    assign miss_vld = work && (miss_pend || (req_vld && !hit && !rsp_full));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_full  <= 1'b0;
            miss_pend <= 1'b0;
        end else if (!work) begin
            rsp_full  <= 1'b0;
            miss_pend <= 1'b0;
        end else begin
            if (take_req) begin
                rsp_full <= 1'b1;
            end else if (rsp_rdy) begin
                rsp_full <= 1'b0;
            end

            if (fill) begin
                miss_pend <= 1'b0;
            end else if (req_vld && !hit && !rsp_full) begin
                miss_pend <= 1'b1;
            end
        end
    end

    // ====================
    // Response register
    // ====================
    always_ff @(posedge clk) begin
        if (take_req) begin
            rsp_dat <= fill ? fill_data : hit_data;
        end
    end

    assign rsp_vld = rsp_full;

endmodule

// File: wca_top.sv
`timescale 1ns/1ps

module wca_top #(
    parameter int NUM_PORTS = wca_pkg::NUM_PORTS_DEF,
    parameter int ADDR_W    = wca_pkg::ADDR_W_DEF,
    parameter int DATA_W    = wca_pkg::DATA_W_DEF,
    parameter int TAG_W     = wca_pkg::TAG_W_DEF,
    parameter int SLOT_NUM  = wca_pkg::SLOT_NUM_DEF
) (
    input  logic                                clk,
    input  logic                                rst_n,

    input  logic                                cfg_info_vld,
    output logic                                cfg_info_rdy,
    input  logic                                cfg_wbuf_ena,

    input  logic                                idx_vld,       // From flag buffer
    output logic                                idx_rdy,
    input  logic [TAG_W-1:0]                    idx,

    input  logic [NUM_PORTS-1:0]                req_vld,       // From PE rows
    output logic [NUM_PORTS-1:0]                req_rdy,
    input  logic [NUM_PORTS-1:0][ADDR_W-1:0]    req_addr,
    input  logic [NUM_PORTS-1:0][TAG_W-1:0]     req_tag,

    output logic [NUM_PORTS-1:0]                rsp_vld,       // To PE rows
    input  logic [NUM_PORTS-1:0]                rsp_rdy,
    output logic [NUM_PORTS-1:0][DATA_W-1:0]    rsp_dat,

    output logic                                wram_add_vld,  // Weight RAM read port
    input  logic                                wram_add_rdy,
    output logic [ADDR_W-1:0]                   wram_add_add,
    input  logic                                wram_dat_vld,
    output logic                                wram_dat_rdy,
    input  logic [DATA_W-1:0]                   wram_dat_dat
);

    localparam int PORT_W = $clog2(NUM_PORTS);

    logic                               work;
    wca_pkg::wca_mode_e                 mode;
    logic [NUM_PORTS-1:0]               hit;
    logic [NUM_PORTS-1:0][DATA_W-1:0]   hit_data;
    logic [NUM_PORTS-1:0]               miss_vld;
    logic                               fill;
    logic [PORT_W-1:0]                  fill_port;
    logic [DATA_W-1:0]                  fill_data;

    wca_cfg_ctrl u_cfg_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_info_vld (cfg_info_vld),
        .cfg_wbuf_ena (cfg_wbuf_ena),
        .cfg_info_rdy (cfg_info_rdy),
        .work         (work),
        .mode         (mode)
    );

    wca_tag_store #(
        .NUM_PORTS (NUM_PORTS),
        .DATA_W    (DATA_W),
        .TAG_W     (TAG_W),
        .SLOT_NUM  (SLOT_NUM)
    ) u_tag_store (
        .clk       (clk),
        .rst_n     (rst_n),
        .work      (work),
        .mode      (mode),
        .idx_vld   (idx_vld),
        .idx       (idx),
        .idx_rdy   (idx_rdy),
        .req_tag   (req_tag),
        .hit       (hit),
        .hit_data  (hit_data),
        .fill      (fill),
        .fill_port (fill_port),
        .fill_data (fill_data)
    );

    wca_req_arbiter #(
        .NUM_PORTS (NUM_PORTS),
        .ADDR_W    (ADDR_W),
        .DATA_W    (DATA_W)
    ) u_req_arbiter (
        .clk          (clk),
        .rst_n        (rst_n),
        .work         (work),
        .miss_vld     (miss_vld),
        .req_addr     (req_addr),
        .wram_add_vld (wram_add_vld),
        .wram_add_rdy (wram_add_rdy),
        .wram_add_add (wram_add_add),
        .wram_dat_vld (wram_dat_vld),
        .wram_dat_rdy (wram_dat_rdy),
        .wram_dat_dat (wram_dat_dat),
        .fill         (fill),
        .fill_port    (fill_port),
        .fill_data    (fill_data)
    );

    // ====================
    // One stage per PE row
    // ====================
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        logic port_fill;

        assign port_fill = fill && (fill_port == PORT_W'(p));   // Strobe for this row only

        wca_port_stage #(
            .DATA_W (DATA_W)
        ) u_port_stage (
            .clk       (clk),
            .rst_n     (rst_n),
            .work      (work),
            .req_vld   (req_vld[p]),
            .req_rdy   (req_rdy[p]),
            .hit       (hit[p]),
            .hit_data  (hit_data[p]),
            .miss_vld  (miss_vld[p]),
            .fill      (port_fill),
            .fill_data (fill_data),
            .rsp_vld   (rsp_vld[p]),
            .rsp_rdy   (rsp_rdy[p]),
            .rsp_dat   (rsp_dat[p])
        );
    end

endmodule

// File: wca_tb.sv
`timescale 1ns/1ps

module wca_tb;

    localparam int          NP   = wca_pkg::NUM_PORTS_DEF;
    localparam int          AW   = wca_pkg::ADDR_W_DEF;
    localparam int          DW   = wca_pkg::DATA_W_DEF;
    localparam int          TW   = wca_pkg::TAG_W_DEF;
    localparam logic [31:0] SEED = 32'h628a_ea9f;

    logic                   clk;
    logic                   rst_n;
    logic                   cfg_info_vld;
    logic                   cfg_info_rdy;
    logic                   cfg_wbuf_ena;
    logic                   idx_vld;
    logic                   idx_rdy;
    logic [TW-1:0]          idx;
    logic [NP-1:0]          req_vld;
    logic [NP-1:0]          req_rdy;
    logic [NP-1:0][AW-1:0]  req_addr;
    logic [NP-1:0][TW-1:0]  req_tag;
    logic [NP-1:0]          rsp_vld;
    logic [NP-1:0]          rsp_rdy;
    logic [NP-1:0][DW-1:0]  rsp_dat;
    logic                   wram_add_vld;
    logic                   wram_add_rdy;
    logic [AW-1:0]          wram_add_add;
    logic                   wram_dat_vld;
    logic                   wram_dat_rdy;
    logic [DW-1:0]          wram_dat_dat;

    // Stimulus table, one entry per request
    int             tab_phase[$];
    int             tab_port[$];
    logic [AW-1:0]  tab_addr[$];
    logic [TW-1:0]  tab_tag[$];
    int             tab_ram[$];     // 1 when the request must read the RAM
    int             load_phase[$];
    logic [TW-1:0]  load_tag[$];
    logic           phase_cache[4] = '{1'b0, 1'b1, 1'b1, 1'b1};

    logic [DW-1:0]  exp_q[NP][$];   // Expected data per port, in request order
    logic [31:0]    rnd = SEED;
    int             ram_reads = 0;
    int             rsp_cnt = 0;
    int             cycles = 0;
    int             cycle_limit = 0;

    wca_top u_wca_top (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [DW-1:0] mem_val(input logic [AW-1:0] a);
        logic [31:0] v;
        v = 32'(a) * 32'd7 + 32'd3;
        return v[DW-1:0];
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    task automatic add_row(input int ph, input int p, input logic [AW-1:0] a,
                           input logic [TW-1:0] t, input int ram);
        tab_phase.push_back(ph);
        tab_port.push_back(p);
        tab_addr.push_back(a);
        tab_tag.push_back(t);
        tab_ram.push_back(ram);
    endtask

    task automatic queue_tag(input int ph, input logic [TW-1:0] t);
        load_phase.push_back(ph);
        load_tag.push_back(t);
    endtask

    task automatic build_table();
        // ====================
        // Phase 0 bypass, tag 1 loaded but never used
        queue_tag(0, 8'd1);
        add_row(0, 0, 13'h0010, 8'd1, 1);
        add_row(0, 0, 13'h0010, 8'd1, 1);   // Same address reads again
        add_row(0, 1, 13'h1abc, 8'd1, 1);
        add_row(0, 1, 13'h0005, 8'd1, 1);
        add_row(0, 2, 13'h0fff, 8'd1, 1);
        add_row(0, 2, 13'h0123, 8'd1, 1);
        add_row(0, 3, 13'h1fff, 8'd1, 1);
        add_row(0, 3, 13'h0000, 8'd1, 1);
        // ====================
        // Phase 1 cache, one port
        queue_tag(1, 8'd5);
        queue_tag(1, 8'd9);
        queue_tag(1, 8'd12);
        add_row(1, 0, 13'h0040, 8'd5, 1);
        add_row(1, 0, 13'h0040, 8'd5, 0);
        add_row(1, 0, 13'h0090, 8'd9, 1);
        add_row(1, 0, 13'h0040, 8'd5, 0);
        add_row(1, 0, 13'h0090, 8'd9, 0);
        add_row(1, 0, 13'h1234, 8'd200, 1);   // Never loaded
        add_row(1, 0, 13'h1234, 8'd200, 1);
        // ====================
        // Phase 2 cache, all ports at once with their own tags
        for (int p = 0; p < NP; p++) begin
            queue_tag(2, TW'(16 + 2 * p));
            queue_tag(2, TW'(17 + 2 * p));
            add_row(2, p, AW'(13'h0200 + 2 * p), TW'(16 + 2 * p), 1);
            add_row(2, p, AW'(13'h0200 + 2 * p), TW'(16 + 2 * p), 0);
            add_row(2, p, AW'(13'h0a31 + 5 * p), TW'(17 + 2 * p), 1);
            add_row(2, p, AW'(13'h0a31 + 5 * p), TW'(17 + 2 * p), 0);
        end
        add_row(2, 3, 13'h0777, 8'd99, 1);
        // ====================
        // Phase 3 cache again after abort, phase 1 tags reloaded
        queue_tag(3, 8'd5);
        queue_tag(3, 8'd9);
        queue_tag(3, 8'd12);
        add_row(3, 0, 13'h0040, 8'd5, 1);
        add_row(3, 0, 13'h0040, 8'd5, 0);
        add_row(3, 1, 13'h0090, 8'd9, 1);
        add_row(3, 1, 13'h0090, 8'd9, 0);
        add_row(3, 1, 13'h00c0, 8'd12, 1);
    endtask

    // Returns to idle first when the controller is working
    task automatic configure(input logic cache);
        if (!cfg_info_rdy) begin
            @(negedge clk);
            cfg_info_vld = 1'b1;
            @(negedge clk);
            cfg_info_vld = 1'b0;
            check(32'(cfg_info_rdy), 32'd1, "cfg_info_rdy after abort");
        end
        @(negedge clk);
        cfg_info_vld = 1'b1;
        cfg_wbuf_ena = cache;
        @(negedge clk);
        cfg_info_vld = 1'b0;
        check(32'(idx_rdy), 32'd0, "idx_rdy in config step");
        @(negedge clk);
        check(32'(idx_rdy), 32'd1, "idx_rdy two cycles after config");
    endtask

    task automatic load_tags(input int ph);
        for (int i = 0; i < load_tag.size(); i++) begin
            if (load_phase[i] == ph) begin
                @(negedge clk);
                idx_vld = 1'b1;
                idx     = load_tag[i];
            end
        end
        @(negedge clk);
        idx_vld = 1'b0;
    endtask

    task automatic drive_port(input int p, input int ph);
        for (int i = 0; i < tab_port.size(); i++) begin
            if (tab_phase[i] == ph && tab_port[i] == p) begin
                @(negedge clk);
                req_vld[p]  = 1'b1;
                req_addr[p] = tab_addr[i];
                req_tag[p]  = tab_tag[i];
                exp_q[p].push_back(mem_val(tab_addr[i]));
                @(posedge clk);
                while (!req_rdy[p]) @(posedge clk);   // Held until accepted
            end
        end
        @(negedge clk);
        req_vld[p] = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rnd <= SEED;
        end else begin
            rnd <= xorshift(rnd);
        end
    end

    initial begin
        rsp_rdy = '0;
        forever begin
            @(negedge clk);
            rsp_rdy = rnd[3:0] | rnd[7:4];   // About three quarters ready
        end
    end

    // ====================
    // Weight RAM model
    // ====================
    initial begin : ram_model
        logic [AW-1:0] raddr;
        int            lat;
        logic          addr_ok;
        wram_add_rdy = 1'b0;
        wram_dat_vld = 1'b0;
        wram_dat_dat = '0;
        forever begin
            @(negedge clk);
            wram_dat_vld = 1'b0;
            wram_add_rdy = (rnd[9:8] != 2'b00);   // Random address stalls
            @(posedge clk);
            if (wram_add_vld && wram_add_rdy) begin
                raddr = wram_add_add;
                // Address must belong to a request still held by its port
                addr_ok = 1'b0;
                for (int p = 0; p < NP; p++) begin
                    if (req_vld[p] && req_addr[p] == raddr) begin
                        addr_ok = 1'b1;
                    end
                end
                check(32'(addr_ok), 32'd1, "RAM address of a waiting request");
                ram_reads++;
                @(negedge clk);
                wram_add_rdy = 1'b0;
                lat = int'(rnd[13:12]) + 1;
                repeat (lat - 1) @(negedge clk);
                wram_dat_vld = 1'b1;
                wram_dat_dat = mem_val(raddr);
                @(posedge clk);
                while (!wram_dat_rdy) @(posedge clk);
            end
        end
    end

    always @(posedge clk) begin
        for (int p = 0; p < NP; p++) begin
            if (rsp_vld[p] && rsp_rdy[p]) begin
                if (exp_q[p].size() == 0) begin
                    $display("Port %0d gave a response that nobody requested", p);
                    $display("Verification failed");
                    $fatal(1);
                end else begin
                    check(32'(rsp_dat[p]), 32'(exp_q[p].pop_front()), "response data");
                    rsp_cnt++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Verification failed");
            $fatal(1);
        end
    end

    initial begin : main
        int exp_reads;
        int n_rows;
        int reads_before;
        int rsp_before;
        rst_n        = 1'b0;
        cfg_info_vld = 1'b0;
        cfg_wbuf_ena = 1'b0;
        idx_vld      = 1'b0;
        idx          = '0;
        req_vld      = '0;
        req_addr     = '0;
        req_tag      = '0;
        build_table();
        cycle_limit = tab_port.size() * 40;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check(32'(cfg_info_rdy), 32'd1, "cfg_info_rdy after reset");
        check(32'(rsp_vld), 32'd0, "rsp_vld after reset");
        check(32'(req_rdy), 32'd0, "req_rdy after reset");
        check(32'(idx_rdy), 32'd0, "idx_rdy after reset");
        check(32'(wram_add_vld), 32'd0, "wram_add_vld after reset");
        check(32'(wram_dat_rdy), 32'd0, "wram_dat_rdy after reset");
        for (int ph = 0; ph < 4; ph++) begin
            configure(phase_cache[ph]);
            load_tags(ph);
            exp_reads = 0;
            n_rows    = 0;
            for (int i = 0; i < tab_port.size(); i++) begin
                if (tab_phase[i] == ph) begin
                    n_rows++;
                    exp_reads += tab_ram[i];
                end
            end
            reads_before = ram_reads;
            rsp_before   = rsp_cnt;
            fork
                drive_port(0, ph);
                drive_port(1, ph);
                drive_port(2, ph);
                drive_port(3, ph);
            join
            while (rsp_cnt < rsp_before + n_rows) @(negedge clk);
            check(32'(ram_reads - reads_before), 32'(exp_reads), "RAM read count");
        end
        $display("Verification passed");
        $finish;
    end

endmodule

// File: flist.f
wca_pkg.sv
wca_cfg_ctrl.sv
wca_tag_store.sv
wca_req_arbiter.sv
wca_port_stage.sv
wca_top.sv
wca_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= wca_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
SRCS      := $(wildcard *.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
